//--- all.f
+incdir+include
hw/vdp_pkg.sv
hw/vdp_if.sv
hw/vdp_timing.sv
hw/vdp_register.sv
hw/vdp_interrupt.sv
hw/vdp_vram_access.sv
hw/vdp_core.sv
sim/vdp_checker.sv
sim/tb_vdp.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_vdp
FILELIST   := all.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
PASS_MSG   := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_vdp.sv
// Testbench for vdp_core with 16-line frames and CPU accesses spaced 16 clocks apart
`timescale 1ns/100ps
`include "vdp_port_modes.svh"

module tb_vdp;

  localparam int          H_TOTAL     = `DEFAULT_H_TOTAL;
  localparam int          V_TOTAL     = 16;
  localparam int          V_ACTIVE    = 12;
  localparam int          FRAME       = H_TOTAL * V_TOTAL;
  localparam int          ACCESS_GAP  = 16;
  localparam int          ACK_LIMIT   = 4;
  localparam int          NUM_BYTES   = 8;
  localparam int          HOLD_CYCLES = 4;
  localparam logic [16:0] BASE_ADDR   = 17'h12A50;

  // Clock on RESET and asynchronous reset on CLK21M
  logic        RESET;
  logic        CLK21M;
  logic        req;
  logic        wrt;
  logic [1:0]  mode;
  logic [7:0]  dbo;
  logic [7:0]  dbi;
  logic        ack;
  logic        int_n;
  logic [16:0] pramadr;
  logic [7:0]  pramdbo;
  logic [7:0]  pramdbi;
  logic        pramwe_n;

  logic        exp_dbi_on;
  logic [7:0]  exp_dbi;
  logic        exp_int_on;
  logic        exp_int_n;
  logic [16:0] exp_wr_addr;
  logic [7:0]  exp_wr_data;
  int          mismatches;
  int          chk_timeouts;
  int          tb_timeouts;
  integer      seed;
  int          i;
  logic [7:0]  data;
  logic [7:0]  written [NUM_BYTES];
  logic        model_vblank;
  logic        model_line;
  logic [7:0]  vram_mem [0:(1 << 17) - 1];

  vdp_core #(
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL),
    .V_ACTIVE (V_ACTIVE)
  ) dut_i (
    .RESET    (RESET),
    .CLK21M   (CLK21M),
    .req      (req),
    .wrt      (wrt),
    .mode     (mode),
    .dbo      (dbo),
    .dbi      (dbi),
    .ack      (ack),
    .int_n    (int_n),
    .pramadr  (pramadr),
    .pramdbo  (pramdbo),
    .pramdbi  (pramdbi),
    .pramwe_n (pramwe_n)
  );

  vdp_checker checker_i (
    .RESET       (RESET),
    .CLK21M      (CLK21M),
    .req         (req),
    .wrt         (wrt),
    .mode        (mode),
    .ack         (ack),
    .dbi         (dbi),
    .int_n       (int_n),
    .pramadr     (pramadr),
    .pramdbo     (pramdbo),
    .pramwe_n    (pramwe_n),
    .exp_dbi_on  (exp_dbi_on),
    .exp_dbi     (exp_dbi),
    .exp_int_on  (exp_int_on),
    .exp_int_n   (exp_int_n),
    .exp_wr_addr (exp_wr_addr),
    .exp_wr_data (exp_wr_data),
    .mismatches  (mismatches),
    .timeouts    (chk_timeouts)
  );

  always #5 RESET = ~RESET;

  // ------------------------------
  // VRAM model
  // ------------------------------
  assign pramdbi = vram_mem[pramadr];

  always @(posedge RESET) begin
    if (!pramwe_n) begin
      vram_mem[pramadr] <= pramdbo;
    end
  end

  initial begin
    for (int a = 0; a < (1 << 17); a++) begin
      vram_mem[a] = 8'(a ^ (a >> 7) ^ (a >> 14));
    end
  end

  // Expected status byte or n-th data read
  function automatic logic [7:0] predict(input logic is_status, input int sel, input int idx);
    logic [7:0] value;
    value = 8'h00;
    if (is_status) begin
      if (sel == 0) begin
        value[7] = model_vblank;
      end else if (sel == 1) begin
        value[0] = model_line;
      end
    end else begin
      value = written[idx];
    end
    return value;
  endfunction

  // ------------------------------
  // CPU port tasks
  // ------------------------------
  task automatic cpu_access(input logic is_wr, input logic [1:0] port, input logic [7:0] value);
    int   n;
    logic seen;
    req  = 1'b1;
    wrt  = is_wr;
    mode = port;
    dbo  = value;
    @(negedge RESET);
    req  = 1'b0;
    n    = 1;
    seen = ack;
    while (!seen && n < ACK_LIMIT) begin
      @(negedge RESET);
      n++;
      seen = ack;
    end
    if (!seen) begin
      $display("Timeout at %0d ns, no ack after a CPU strobe", $time);
      tb_timeouts++;
    end
    while (n < ACCESS_GAP) begin
      @(negedge RESET);
      n++;
    end
  endtask

  task automatic write_reg(input logic [5:0] num, input logic [7:0] value);
    cpu_access(1'b1, vdp_pkg::PORT_CTRL, value);
    cpu_access(1'b1, vdp_pkg::PORT_CTRL, {2'b10, num});
  endtask

  // Bits 7:6 of the second byte are 01 for writing and 00 for reading
  task automatic set_address(input logic [16:0] addr, input logic for_write);
    write_reg(vdp_pkg::REG_ADDR_HIGH, {5'b00000, addr[16:14]});
    cpu_access(1'b1, vdp_pkg::PORT_CTRL, addr[7:0]);
    cpu_access(1'b1, vdp_pkg::PORT_CTRL, {1'b0, for_write, addr[13:8]});
  endtask

  task automatic read_port(input logic [1:0] port, input logic check, input logic [7:0] want);
    exp_dbi    = want;
    exp_dbi_on = check;
    cpu_access(1'b0, port, 8'h00);
    exp_dbi_on = 1'b0;
  endtask

  task automatic wait_int_n(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (int_n !== level && n < limit) begin
      @(negedge RESET);
      n++;
    end
    if (int_n !== level) begin
      $display("Timeout at %0d ns waiting for %s", $time, what);
      tb_timeouts++;
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    RESET        = 1'b0;
    CLK21M       = 1'b0;
    req          = 1'b0;
    wrt          = 1'b0;
    mode         = 2'b00;
    dbo          = 8'h00;
    exp_dbi_on   = 1'b0;
    exp_dbi      = 8'h00;
    exp_int_on   = 1'b1;
    exp_int_n    = 1'b1;
    exp_wr_addr  = '0;
    exp_wr_data  = 8'h00;
    model_vblank = 1'b0;
    model_line   = 1'b0;
    tb_timeouts  = 0;
    seed         = 32'h6922;
    // Reset edge after time zero so the flops see it
    #2;
    CLK21M = 1'b1;
    repeat (16) @(negedge RESET);
    CLK21M = 1'b0;
    repeat (4) @(negedge RESET);

    // Write burst of random bytes
    set_address(BASE_ADDR, 1'b1);
    for (i = 0; i < NUM_BYTES; i++) begin
      data        = 8'($random(seed));
      written[i]  = data;
      exp_wr_addr = BASE_ADDR + 17'(i);
      exp_wr_data = data;
      cpu_access(1'b1, vdp_pkg::PORT_DATA, data);
    end

    // Read back through the read-ahead latch
    set_address(BASE_ADDR, 1'b0);
    for (i = 0; i < NUM_BYTES; i++) begin
      read_port(vdp_pkg::PORT_DATA, 1'b1, predict(1'b0, 0, i));
    end

    // Vertical blank interrupt
    // Stale flag cleared first
    read_port(vdp_pkg::PORT_CTRL, 1'b0, 8'h00);
    exp_int_on = 1'b0;
    write_reg(vdp_pkg::REG_MODE1, 8'(1 << vdp_pkg::BIT_VBLANK_IRQ_EN));
    wait_int_n(1'b0, FRAME + 2 * H_TOTAL, "int_n to fall on vertical blank");
    // Flag holds until the status read
    exp_int_n  = 1'b0;
    exp_int_on = 1'b1;
    repeat (HOLD_CYCLES) @(negedge RESET);
    exp_int_on   = 1'b0;
    model_vblank = 1'b1;
    read_port(vdp_pkg::PORT_CTRL, 1'b1, predict(1'b1, 0, 0));
    model_vblank = 1'b0;
    exp_int_n    = 1'b1;
    exp_int_on   = 1'b1;
    read_port(vdp_pkg::PORT_CTRL, 1'b1, predict(1'b1, 0, 0));
    write_reg(vdp_pkg::REG_MODE1, 8'h00);

    // Line interrupt on line 5 through S1
    write_reg(vdp_pkg::REG_LINE_IRQ, 8'd5);
    write_reg(vdp_pkg::REG_STATUS_SEL, 8'd1);
    read_port(vdp_pkg::PORT_CTRL, 1'b0, 8'h00);
    exp_int_on = 1'b0;
    write_reg(vdp_pkg::REG_MODE0, 8'(1 << vdp_pkg::BIT_LINE_IRQ_EN));
    wait_int_n(1'b0, FRAME + 2 * H_TOTAL, "int_n to fall on the line match");
    exp_int_n  = 1'b0;
    exp_int_on = 1'b1;
    repeat (HOLD_CYCLES) @(negedge RESET);
    exp_int_on = 1'b0;
    model_line = 1'b1;
    read_port(vdp_pkg::PORT_CTRL, 1'b1, predict(1'b1, 1, 0));
    model_line = 1'b0;
    exp_int_n  = 1'b1;
    exp_int_on = 1'b1;
    write_reg(vdp_pkg::REG_MODE0, 8'h00);
    // With both enables off int_n stays high
    repeat (2 * FRAME) @(negedge RESET);

    $display("Run complete: %0d value errors, %0d timeouts", mismatches,
             tb_timeouts + chk_timeouts);
    if (mismatches == 0 && tb_timeouts == 0 && chk_timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- sim/vdp_checker.sv
// Compares vdp_core responses with expectations from the testbench, assumes accesses 8 or more clocks apart
`timescale 1ns/100ps

module vdp_checker (
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        req,
  input  logic        wrt,
  input  logic [1:0]  mode,
  input  logic        ack,
  input  logic [7:0]  dbi,
  input  logic        int_n,
  input  logic [16:0] pramadr,
  input  logic [7:0]  pramdbo,
  input  logic        pramwe_n,
  input  logic        exp_dbi_on,
  input  logic [7:0]  exp_dbi,
  input  logic        exp_int_on,
  input  logic        exp_int_n,
  input  logic [16:0] exp_wr_addr,
  input  logic [7:0]  exp_wr_data,
  output int          mismatches,
  output int          timeouts
);

  localparam int STROBE_LIMIT = 8;

  int          port_errs = 0;
  int          strobe_errs = 0;
  int          strobe_timeouts = 0;
  logic        req_d = 1'b0;
  logic        rd_d = 1'b0;
  logic        wr_wait = 1'b0;
  logic        seen;
  logic [16:0] want_addr;
  logic [7:0]  want_data;
  int          n;

  assign mismatches = port_errs + strobe_errs;
  assign timeouts   = strobe_timeouts;

  function automatic int differs(input string name, input logic [16:0] got,
                                 input logic [16:0] want);
    if (got !== want) begin
      $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, want, got);
      return 1;
    end
    return 0;
  endfunction

  // ------------------------------
  // CPU port and interrupt output
  // ------------------------------
  always @(posedge RESET) begin
    if (CLK21M) begin
      port_errs = port_errs + differs("ack", 17'(ack), 17'(1'b0));
      port_errs = port_errs + differs("int_n", 17'(int_n), 17'(1'b1));
      port_errs = port_errs + differs("pramwe_n", 17'(pramwe_n), 17'(1'b1));
      req_d = 1'b0;
      rd_d  = 1'b0;
    end else begin
      // ack follows an accepted strobe by one clock
      port_errs = port_errs + differs("ack", 17'(ack), 17'(req_d));
      if (req_d && rd_d && exp_dbi_on) begin
        port_errs = port_errs + differs("dbi", 17'(dbi), 17'(exp_dbi));
      end
      if (exp_int_on) begin
        port_errs = port_errs + differs("int_n", 17'(int_n), 17'(exp_int_n));
      end
      if (!pramwe_n && !wr_wait) begin
        $display("VRAM write strobe at %0d ns without a data write pending", $time);
        port_errs = port_errs + 1;
      end
      req_d = req;
      rd_d  = req && !wrt;
    end
  end

  // ------------------------------
  // VRAM write strobes
  // ------------------------------
  always @(posedge RESET) begin
    if (!CLK21M && req && wrt && (mode == vdp_pkg::PORT_DATA)) begin
      want_addr = exp_wr_addr;
      want_data = exp_wr_data;
      wr_wait <= 1'b1;
      seen = 1'b0;
      for (n = 0; n < STROBE_LIMIT && !seen; n++) begin
        @(posedge RESET);
        if (!pramwe_n) begin
          seen = 1'b1;
          strobe_errs = strobe_errs + differs("pramadr", pramadr, want_addr);
          strobe_errs = strobe_errs + differs("pramdbo", 17'(pramdbo), 17'(want_data));
        end
      end
      wr_wait <= 1'b0;
      if (!seen) begin
        $display("Timeout at %0d ns waiting for the VRAM write strobe of a data write", $time);
        strobe_timeouts = strobe_timeouts + 1;
      end
    end
  end

endmodule

//--- hw/vdp_core.sv
// Host-facing VDP core without display, frame sizes default to the shared header values
`timescale 1ns/100ps
`include "vdp_port_modes.svh"

module vdp_core #(
  parameter int H_TOTAL  = `DEFAULT_H_TOTAL,
  parameter int V_TOTAL  = `DEFAULT_V_TOTAL,
  parameter int V_ACTIVE = `DEFAULT_V_ACTIVE
) (
  input  logic        RESET,
  input  logic        CLK21M,
  input  logic        req,
  input  logic        wrt,
  input  logic [1:0]  mode,
  input  logic [7:0]  dbo,
  output logic [7:0]  dbi,
  output logic        ack,
  output logic        int_n,
  output logic [16:0] pramadr,
  output logic [7:0]  pramdbo,
  input  logic [7:0]  pramdbi,
  output logic        pramwe_n
);

  vdp_pkg::dot_phase_t dot_phase;
  vdp_pkg::line_t      line;
  logic                line_start;
  logic                vblank_start;

  vram_req_if vram_bus ();
  irq_if      irq_bus ();

  // ------------------------------
  // Blocks
  // ------------------------------
  vdp_timing #(
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL),
    .V_ACTIVE (V_ACTIVE)
  ) timing_i (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .dot_phase    (dot_phase),
    .line         (line),
    .line_start   (line_start),
    .vblank_start (vblank_start)
  );

  vdp_register register_i (
    .RESET  (RESET),
    .CLK21M (CLK21M),
    .req    (req),
    .wrt    (wrt),
    .mode   (vdp_pkg::port_mode_t'(mode)),
    .dbo    (dbo),
    .dbi    (dbi),
    .ack    (ack),
    .vram   (vram_bus.regs),
    .irq    (irq_bus.regs)
  );

  vdp_interrupt interrupt_i (
    .RESET        (RESET),
    .CLK21M       (CLK21M),
    .line         (line),
    .line_start   (line_start),
    .vblank_start (vblank_start),
    .irq          (irq_bus.irq),
    .int_n        (int_n)
  );

  vdp_vram_access vram_access_i (
    .RESET     (RESET),
    .CLK21M    (CLK21M),
    .dot_phase (dot_phase),
    .vram      (vram_bus.mem),
    .pramadr   (pramadr),
    .pramdbo   (pramdbo),
    .pramdbi   (pramdbi),
    .pramwe_n  (pramwe_n)
  );

endmodule

//--- hw/vdp_vram_access.sv
// CPU VRAM slot once per four clocks, writes win over reads, VRAM must answer reads within one clock
`timescale 1ns/100ps

module vdp_vram_access (
  input  logic                RESET,
  input  logic                CLK21M,
  input  vdp_pkg::dot_phase_t dot_phase,
  vram_req_if.mem             vram,
  output vdp_pkg::vram_addr_t pramadr,
  output vdp_pkg::byte_t      pramdbo,
  input  vdp_pkg::byte_t      pramdbi,
  output logic                pramwe_n
);

  logic busy;
  logic sel_wr;
  logic wr_pending;
  logic rd_pending;

  assign wr_pending = (vram.wr_req != vram.wr_ack);
  assign rd_pending = (vram.rd_req != vram.rd_ack);

  // ------------------------------
  // Slot sequencing
  // ------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      busy        <= 1'b0;
      sel_wr      <= 1'b0;
      pramwe_n    <= 1'b1;
      vram.wr_ack <= 1'b0;
      vram.rd_ack <= 1'b0;
    end else begin
      if (dot_phase == vdp_pkg::DOT_PHASE_ADDR) begin
        busy     <= wr_pending || rd_pending;
        sel_wr   <= wr_pending;
        // Strobe falls for the whole slot cycle
        pramwe_n <= !wr_pending;
      end else if (dot_phase == vdp_pkg::DOT_PHASE_SLOT) begin
        pramwe_n <= 1'b1;
        busy     <= 1'b0;
        if (busy && sel_wr) begin
          vram.wr_ack <= ~vram.wr_ack;
        end
        if (busy && !sel_wr) begin
          vram.rd_ack <= ~vram.rd_ack;
        end
      end
    end
  end

  // Address and data stay put until the next pick
  always_ff @(posedge RESET) begin
    if ((dot_phase == vdp_pkg::DOT_PHASE_ADDR) && (wr_pending || rd_pending)) begin
      pramadr <= vram.addr;
      if (wr_pending) begin
        pramdbo <= vram.wr_data;
      end
    end
    // Read data sampled at the end of the slot
    if ((dot_phase == vdp_pkg::DOT_PHASE_SLOT) && busy && !sel_wr) begin
      vram.rd_data <= pramdbi;
    end
  end

  assert property (@(posedge RESET) disable iff (CLK21M)
    !pramwe_n |=> pramwe_n)
    else $error("pramwe_n low for more than one cycle");

endmodule

//--- hw/vdp_interrupt.sv
// Vertical blank and line interrupts, one combined active-low output that is registered
`timescale 1ns/100ps

module vdp_interrupt (
  input  logic           RESET,
  input  logic           CLK21M,
  input  vdp_pkg::line_t line,
  input  logic           line_start,
  input  logic           vblank_start,
  irq_if.irq             irq,
  output logic           int_n
);

  logic vblank_flag;
  logic line_flag;
  logic line_hit;

  // Compare only at the start of a line
  assign line_hit = line_start && (line == irq.line_match);

  // ------------------------------
  // Flags and output
  // ------------------------------
  // A new event beats a clear in the same clock
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      vblank_flag <= 1'b0;
      line_flag   <= 1'b0;
      int_n       <= 1'b1;
    end else begin
      if (vblank_start) begin
        vblank_flag <= 1'b1;
      end else if (irq.clr_vblank) begin
        vblank_flag <= 1'b0;
      end
      if (line_hit) begin
        line_flag <= 1'b1;
      end else if (irq.clr_line) begin
        line_flag <= 1'b0;
      end
      int_n <= !((irq.vblank_en && vblank_flag) || (irq.line_en && line_flag));
    end
  end

  assign irq.vblank_flag = vblank_flag;
  assign irq.line_flag   = line_flag;

endmodule

//--- hw/vdp_register.sv
// CPU port and control registers, expects accesses at least 8 clocks apart as there is no back-pressure
`timescale 1ns/100ps

module vdp_register (
  input  logic                RESET,
  input  logic                CLK21M,
  input  logic                req,
  input  logic                wrt,
  input  vdp_pkg::port_mode_t mode,
  input  vdp_pkg::byte_t      dbo,
  output vdp_pkg::byte_t      dbi,
  output logic                ack,
  vram_req_if.regs            vram,
  irq_if.regs                 irq
);

  logic                                 data_wr;
  logic                                 data_rd;
  logic                                 ctrl_wr;
  logic                                 ctrl_rd;
  logic                                 second_byte;
  vdp_pkg::byte_t                       ctrl_latch;
  vdp_pkg::vram_addr_t                  vram_ptr;
  vdp_pkg::vram_addr_t                  set_addr;
  logic [vdp_pkg::VRAM_ADDR_W-15:0]     addr_high;
  logic [3:0]                           status_sel;
  logic                                 line_en;
  logic                                 vblank_en;
  vdp_pkg::line_t                       line_match;
  vdp_pkg::byte_t                       status;
  logic                                 wr_pending;
  logic                                 rd_pending;

  // Port decode
  assign data_wr = req && wrt && (mode == vdp_pkg::PORT_DATA);
  assign data_rd = req && !wrt && (mode == vdp_pkg::PORT_DATA);
  assign ctrl_wr = req && wrt && (mode == vdp_pkg::PORT_CTRL);
  assign ctrl_rd = req && !wrt && (mode == vdp_pkg::PORT_CTRL);

  // Address from R14, second byte and first byte
  assign set_addr = {addr_high, dbo[5:0], ctrl_latch};

  assign wr_pending = (vram.wr_req != vram.wr_ack);
  assign rd_pending = (vram.rd_req != vram.rd_ack);

  // ------------------------------
  // Status registers
  // ------------------------------
  always_comb begin
    status = '0;
    if (status_sel <= vdp_pkg::STATUS_SEL_MAX) begin
      if (status_sel[0]) begin
        status[vdp_pkg::STS_LINE_BIT] = irq.line_flag;
      end else begin
        status[vdp_pkg::STS_VBLANK_BIT] = irq.vblank_flag;
      end
    end
  end

  // Reading a status clears its flag
  assign irq.clr_vblank = ctrl_rd && (status_sel == 4'd0);
  assign irq.clr_line   = ctrl_rd && (status_sel == 4'd1);
  assign irq.vblank_en  = vblank_en;
  assign irq.line_en    = line_en;
  assign irq.line_match = line_match;

  // ------------------------------
  // Control state
  // ------------------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ack         <= 1'b0;
      second_byte <= 1'b0;
      vram.wr_req <= 1'b0;
      vram.rd_req <= 1'b0;
      vram_ptr    <= '0;
      addr_high   <= '0;
      status_sel  <= '0;
      line_en     <= 1'b0;
      vblank_en   <= 1'b0;
      line_match  <= '0;
    end else begin
      ack <= req;
      if (data_wr || data_rd || ctrl_rd) begin
        second_byte <= 1'b0;
      end
      if (data_wr) begin
        vram.wr_req <= ~vram.wr_req;
        vram_ptr    <= vram_ptr + 1'b1;
      end
      // Hand out the latch and fetch the next byte
      if (data_rd) begin
        vram.rd_req <= ~vram.rd_req;
        vram_ptr    <= vram_ptr + 1'b1;
      end
      if (ctrl_wr) begin
        if (!second_byte) begin
          second_byte <= 1'b1;
        end else begin
          second_byte <= 1'b0;
          if (dbo[7]) begin
            case (dbo[5:0])
              vdp_pkg::REG_MODE0:      line_en    <= ctrl_latch[vdp_pkg::BIT_LINE_IRQ_EN];
              vdp_pkg::REG_MODE1:      vblank_en  <= ctrl_latch[vdp_pkg::BIT_VBLANK_IRQ_EN];
              vdp_pkg::REG_ADDR_HIGH:  addr_high  <= ctrl_latch[vdp_pkg::VRAM_ADDR_W-15:0];
              vdp_pkg::REG_STATUS_SEL: status_sel <= ctrl_latch[3:0];
              vdp_pkg::REG_LINE_IRQ:   line_match <= ctrl_latch;
              default: ;
            endcase
          end else if (dbo[6]) begin
            vram_ptr <= set_addr;
          end else begin
            // Read setup, prefetch at once
            vram_ptr    <= set_addr + 1'b1;
            vram.rd_req <= ~vram.rd_req;
          end
        end
      end
    end
  end

  // Payload, meaningful only behind its strobe
  always_ff @(posedge RESET) begin
    if (ctrl_wr && !second_byte) begin
      ctrl_latch <= dbo;
    end
    if (data_wr || data_rd) begin
      vram.addr <= vram_ptr;
    end
    if (ctrl_wr && second_byte && (dbo[7:6] == 2'b00)) begin
      vram.addr <= set_addr;
    end
    if (data_wr) begin
      vram.wr_data <= dbo;
    end
    if (data_rd) begin
      dbi <= vram.rd_data;
    end else if (ctrl_rd) begin
      dbi <= status;
    end
  end

  // CPU must not outrun the VRAM slot
  assert property (@(posedge RESET) disable iff (CLK21M)
    ($changed(vram.wr_req) || $changed(vram.rd_req)) |-> !$past(wr_pending || rd_pending))
    else $error("VRAM request issued while another was pending");

endmodule

//--- hw/vdp_timing.sv
// Frame timing for short or full frames, needs H_TOTAL of at least 2 and V_TOTAL of at most 256
`timescale 1ns/100ps

module vdp_timing #(
  parameter int H_TOTAL  = 64,
  parameter int V_TOTAL  = 32,
  parameter int V_ACTIVE = 24
) (
  input  logic                RESET,
  input  logic                CLK21M,
  output vdp_pkg::dot_phase_t dot_phase,
  output vdp_pkg::line_t      line,
  output logic                line_start,
  output logic                vblank_start
);

  localparam int DOT_W = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;

  logic [DOT_W-1:0] dot_cnt;
  vdp_pkg::line_t   line_next;
  logic             dot_wrap;

  // Last clock of the line
  assign dot_wrap  = (dot_cnt == DOT_W'(H_TOTAL - 1));
  assign line_next = (line == vdp_pkg::line_t'(V_TOTAL - 1)) ? '0 : line + 1'b1;

  // ------------------------------
  // Counters
  // ------------------------------
  // Pulses are registered so they line up with dot 0 of the new line
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dot_phase    <= '0;
      dot_cnt      <= '0;
      line         <= '0;
      line_start   <= 1'b0;
      vblank_start <= 1'b0;
    end else begin
      dot_phase    <= dot_phase + 2'd1;
      line_start   <= dot_wrap;
      vblank_start <= dot_wrap && (line_next == vdp_pkg::line_t'(V_ACTIVE));
      if (dot_wrap) begin
        dot_cnt <= '0;
        line    <= line_next;
      end else begin
        dot_cnt <= dot_cnt + 1'b1;
      end
    end
  end

  // Phase never stalls, VRAM slots depend on it
  assert property (@(posedge RESET) disable iff (CLK21M)
    !$past(CLK21M) |-> dot_phase == $past(dot_phase) + 2'd1)
    else $error("dot phase did not advance by one");

endmodule

//--- hw/vdp_if.sv
// Request and interrupt bundles between VDP blocks, the toggle pairs assume one access in flight
`timescale 1ns/100ps

// VRAM access request from the CPU port side
interface vram_req_if;

  // Pending while req and ack toggles differ
  logic                wr_req;
  logic                rd_req;
  vdp_pkg::vram_addr_t addr;
  vdp_pkg::byte_t      wr_data;

  logic                wr_ack;
  logic                rd_ack;
  vdp_pkg::byte_t      rd_data;

  modport regs (
    output wr_req, rd_req, addr, wr_data,
    input  wr_ack, rd_ack, rd_data
  );

  modport mem (
    input  wr_req, rd_req, addr, wr_data,
    output wr_ack, rd_ack, rd_data
  );

endinterface

// Enables, line match and status clears toward the interrupt block
interface irq_if;

  logic           vblank_en;
  logic           line_en;
  vdp_pkg::line_t line_match;
  logic           clr_vblank;
  logic           clr_line;

  logic           vblank_flag;
  logic           line_flag;

  modport regs (
    output vblank_en, line_en, line_match, clr_vblank, clr_line,
    input  vblank_flag, line_flag
  );

  modport irq (
    input  vblank_en, line_en, line_match, clr_vblank, clr_line,
    output vblank_flag, line_flag
  );

endinterface

//--- hw/vdp_pkg.sv
// Types and constants for the VDP host core, 128 KB byte-wide VRAM and status registers S0 and S1 only
package vdp_pkg;

  // ------------------------------
  // Widths and basic types
  // ------------------------------
  localparam int VRAM_ADDR_W = 17;
  localparam int BYTE_W      = 8;
  localparam int LINE_W      = 8;

  typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
  typedef logic [BYTE_W-1:0]      byte_t;
  typedef logic [LINE_W-1:0]      line_t;

  // CPU port select, values 2 and 3 do nothing
  typedef enum logic [1:0] {
    PORT_DATA = 2'd0,
    PORT_CTRL = 2'd1
  } port_mode_t;

  // Four dot phases per VRAM slot
  typedef logic [1:0] dot_phase_t;

  localparam dot_phase_t DOT_PHASE_ADDR = 2'b00;
  localparam dot_phase_t DOT_PHASE_SLOT = 2'b01;

  // ------------------------------
  // Control registers kept
  // ------------------------------
  localparam logic [5:0] REG_MODE0      = 6'd0;
  localparam logic [5:0] REG_MODE1      = 6'd1;
  localparam logic [5:0] REG_ADDR_HIGH  = 6'd14;
  localparam logic [5:0] REG_STATUS_SEL = 6'd15;
  localparam logic [5:0] REG_LINE_IRQ   = 6'd19;

  // Interrupt enables inside R0 and R1
  localparam int BIT_LINE_IRQ_EN   = 4;
  localparam int BIT_VBLANK_IRQ_EN = 5;

  // Status selects above this read as zero
  localparam int STATUS_SEL_MAX = 1;
  localparam int STS_VBLANK_BIT = 7;
  localparam int STS_LINE_BIT   = 0;

endpackage

//--- include/vdp_port_modes.svh
// Default frame sizes for the VDP core, H_TOTAL must stay a multiple of 4 and V_TOTAL at most 256
`ifndef VDP_PORT_MODES_SVH
`define VDP_PORT_MODES_SVH

// Clocks per line
`define DEFAULT_H_TOTAL 64

// Lines per frame and visible lines before vertical blank
`define DEFAULT_V_TOTAL 32
`define DEFAULT_V_ACTIVE 24

`endif
